// File: rtl/id_pkg.sv
// shared widths, opcodes, control codes and bus structs of the decode stage, imported by each module
package id_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      gpr_addr_t;
  typedef logic [XLEN-1:0] imm_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [1:0]      alu_src2_t;
  typedef logic [2:0]      mem_op_t;  // funct3 of load/store

  // alu operations
  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_SLL   = 4'd2;
  localparam alu_op_t ALU_SLT   = 4'd3;
  localparam alu_op_t ALU_SLTU  = 4'd4;
  localparam alu_op_t ALU_XOR   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_OR    = 4'd8;
  localparam alu_op_t ALU_AND   = 4'd9;
  localparam alu_op_t ALU_PASSB = 4'd10;  // lui

  localparam alu_src2_t SRC2_RS2  = 2'd0;
  localparam alu_src2_t SRC2_IMM  = 2'd1;
  localparam alu_src2_t SRC2_FOUR = 2'd2;  // link address for jal/jalr

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef struct packed {
    inst_t inst;
    pc_t   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    word_t     wdata;
  } ws_to_rf_t;

  typedef struct packed {
    logic stall;   // hold fetch until the target is on the fetch bus
    logic taken;
    pc_t  target;
  } br_bus_t;

  typedef struct packed {
    logic      alu_src1_sel;  // 1: pc instead of rs1
    alu_src2_t alu_src2_sel;
    alu_op_t   alu_op;
    gpr_addr_t rd;
    logic      gpr_wen;
    logic      mem_ren;
    logic      mem_wen;
    mem_op_t   mem_op;
    logic      invalid;
  } ds_ctrl_t;

  typedef struct packed {
    word_t    rs1data;
    word_t    rs2data;
    imm_t     imm;
    pc_t      pc;
    ds_ctrl_t ctrl;
  } ds_to_es_t;

endpackage

// File: rtl/id_ctrl.sv
// decode stage control: valid bit, fetch latch, hazard stall and the allowin handshake
`timescale 1ns/1ps

module id_ctrl import id_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_fs_to_ds_valid,
  input  fs_to_ds_t i_fs_to_ds,
  input  logic      i_es_allowin,
  input  gpr_addr_t i_rs1,
  input  gpr_addr_t i_rs2,
  input  gpr_addr_t i_es_rd,
  input  gpr_addr_t i_ms_rd,
  input  gpr_addr_t i_ws_rd,
  input  logic      i_br_taken,
  input  pc_t       i_br_target,
  output inst_t     o_inst,
  output pc_t       o_pc,
  output logic      o_ds_allowin,
  output logic      o_ds_to_es_valid,
  output logic      o_br_stall
);

  logic      ds_valid;
  fs_to_ds_t fs_to_ds_r;
  logic      hazard;
  logic      redirect;
  logic      ready_go;

  // pending write to one of our sources, x0 never pends
  function automatic logic rd_hit(
    input gpr_addr_t rd,
    input gpr_addr_t rs1,
    input gpr_addr_t rs2
  );
    return (rd != '0) && ((rd == rs1) || (rd == rs2));
  endfunction

  assign hazard = rd_hit(i_es_rd, i_rs1, i_rs2) ||
                  rd_hit(i_ms_rd, i_rs1, i_rs2) ||
                  rd_hit(i_ws_rd, i_rs1, i_rs2);

  // fetch is still on the wrong path, or operands not ready yet
  assign redirect = (i_br_taken && (i_br_target != i_fs_to_ds.pc)) || hazard;

  assign ready_go         = !redirect;  // redirect already includes the hazard
  assign o_ds_allowin     = !ds_valid || (ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ready_go;
  assign o_br_stall       = redirect;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;  // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fs_to_ds_r <= '0;  // all-zero word decodes as invalid and never taken
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      fs_to_ds_r <= i_fs_to_ds;
    end
  end

  assign o_inst = fs_to_ds_r.inst;
  assign o_pc   = fs_to_ds_r.pc;

endmodule

// File: rtl/id_decoder.sv
// combinational RV64I decoder producing register indices, immediate and execute controls
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
  input  inst_t      i_inst,
  output gpr_addr_t  o_rs1,
  output gpr_addr_t  o_rs2,
  output imm_t       o_imm,
  output ds_ctrl_t   o_ctrl,
  output logic       o_bren,
  output logic       o_jump,
  output logic       o_jalr,
  output logic [2:0] o_brfunc
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_t       imm_i;
  imm_t       imm_s;
  imm_t       imm_b;
  imm_t       imm_u;
  imm_t       imm_j;
  logic       bad_inst;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rs1    = i_inst[19:15];
  assign o_rs2    = i_inst[24:20];
  assign o_brfunc = funct3;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // shared by OP and OP-IMM, alt picks sub/sra
  function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    o_ctrl              = '0;
    o_ctrl.alu_src2_sel = SRC2_RS2;
    o_ctrl.alu_op       = ALU_ADD;
    o_ctrl.rd           = i_inst[11:7];
    o_ctrl.mem_op       = funct3;
    o_imm               = '0;
    o_bren              = 1'b0;
    o_jump              = 1'b0;
    o_jalr              = 1'b0;
    bad_inst            = 1'b0;
    case (opcode)
      OPC_OP: begin
        o_ctrl.alu_op  = alu_sel(funct3, funct7[5]);
        o_ctrl.gpr_wen = 1'b1;
        bad_inst = !((funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      OPC_OP_IMM: begin
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.alu_op       = alu_sel(funct3, (funct3 == 3'b101) && funct7[5]);
        o_ctrl.gpr_wen      = 1'b1;
        o_imm               = imm_i;
        // 6-bit shamt, only the top six bits are funct
        if (funct3 == 3'b001) begin
          bad_inst = funct7[6:1] != 6'b000000;
        end else if (funct3 == 3'b101) begin
          bad_inst = (funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000);
        end
      end
      OPC_LUI: begin
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.alu_op       = ALU_PASSB;
        o_ctrl.gpr_wen      = 1'b1;
        o_imm               = imm_u;
      end
      OPC_AUIPC: begin
        o_ctrl.alu_src1_sel = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen      = 1'b1;
        o_imm               = imm_u;
      end
      OPC_JAL: begin
        o_ctrl.alu_src1_sel = 1'b1;  // rd = pc + 4
        o_ctrl.alu_src2_sel = SRC2_FOUR;
        o_ctrl.gpr_wen      = 1'b1;
        o_imm               = imm_j;
        o_jump              = 1'b1;
      end
      OPC_JALR: begin
        o_ctrl.alu_src1_sel = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_FOUR;
        o_ctrl.gpr_wen      = 1'b1;
        o_imm               = imm_i;
        o_jalr              = 1'b1;
      end
      OPC_BRANCH: begin
        o_imm  = imm_b;
        o_bren = 1'b1;
      end
      OPC_LOAD: begin
        o_ctrl.alu_src2_sel = SRC2_IMM;  // address = rs1 + imm
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.mem_ren      = 1'b1;
        o_imm               = imm_i;
      end
      OPC_STORE: begin
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.mem_wen      = 1'b1;
        o_imm               = imm_s;
      end
      default: bad_inst = 1'b1;
    endcase
    if (bad_inst) begin
      o_ctrl.gpr_wen = 1'b0;
      o_ctrl.mem_ren = 1'b0;
      o_ctrl.mem_wen = 1'b0;
    end
    o_ctrl.invalid = bad_inst;
  end

endmodule

// File: rtl/id_regfile.sv
// general register file with two combinational read ports and one write-back port
`timescale 1ns/1ps

module id_regfile import id_pkg::*; (
  input  logic      i_clk,
  // read port 1
  input  gpr_addr_t i_raddr1,
  output word_t     o_rdata1,
  // read port 2
  input  gpr_addr_t i_raddr2,
  output word_t     o_rdata2,
  // write port from write-back
  input  ws_to_rf_t i_wb
);

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge i_clk) begin
    if (i_wb.wen && (i_wb.waddr != '0)) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // no bypass, same-cycle write is covered by the ws_rd stall
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: rtl/id_branch.sv
// branch unit resolving taken and next pc for BRANCH, JAL and JALR in decode
`timescale 1ns/1ps

module id_branch import id_pkg::*; (
  input  word_t      i_rs1data,
  input  word_t      i_rs2data,
  input  pc_t        i_pc,
  input  imm_t       i_imm,
  input  logic       i_bren,
  input  logic       i_jump,
  input  logic       i_jalr,
  input  logic [2:0] i_brfunc,
  output logic       o_br_taken,
  output pc_t        o_br_target
);

  logic cond;
  pc_t  jalr_sum;

  always_comb begin
    case (i_brfunc)
      3'b000:  cond = i_rs1data == i_rs2data;                  // beq
      3'b001:  cond = i_rs1data != i_rs2data;                  // bne
      3'b100:  cond = $signed(i_rs1data) <  $signed(i_rs2data); // blt
      3'b101:  cond = $signed(i_rs1data) >= $signed(i_rs2data); // bge
      3'b110:  cond = i_rs1data <  i_rs2data;                  // bltu
      3'b111:  cond = i_rs1data >= i_rs2data;                  // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1data + i_imm;

  assign o_br_taken  = i_jump || i_jalr || (i_bren && cond);
  assign o_br_target = i_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : (i_pc + i_imm);

endmodule

// File: rtl/id_stage.sv
// top of the instruction decode stage, joining control, decoder, register file and branch unit
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  // from fetch
  input  logic      i_fs_to_ds_valid,
  input  fs_to_ds_t i_fs_to_ds,
  output logic      o_ds_allowin,
  // to execute
  input  logic      i_es_allowin,
  output logic      o_ds_to_es_valid,
  output ds_to_es_t o_ds_to_es,
  // redirect to fetch
  output br_bus_t   o_br,
  // write-back port
  input  ws_to_rf_t i_wb,
  // destinations still in flight
  input  gpr_addr_t i_es_rd,
  input  gpr_addr_t i_ms_rd,
  input  gpr_addr_t i_ws_rd
);

  inst_t      ds_inst;
  pc_t        ds_pc;
  gpr_addr_t  rs1;
  gpr_addr_t  rs2;
  imm_t       imm;
  ds_ctrl_t   ctrl;
  word_t      rs1data;
  word_t      rs2data;
  logic       bren;
  logic       jump;
  logic       jalr;
  logic [2:0] brfunc;
  logic       br_taken;
  pc_t        br_target;
  logic       br_stall;

  id_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds       (i_fs_to_ds),
    .i_es_allowin     (i_es_allowin),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .i_br_taken       (br_taken),
    .i_br_target      (br_target),
    .o_inst           (ds_inst),
    .o_pc             (ds_pc),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_br_stall       (br_stall)
  );

  id_decoder u_dec (
    .i_inst   (ds_inst),
    .o_rs1    (rs1),
    .o_rs2    (rs2),
    .o_imm    (imm),
    .o_ctrl   (ctrl),
    .o_bren   (bren),
    .o_jump   (jump),
    .o_jalr   (jalr),
    .o_brfunc (brfunc)
  );

  id_regfile u_rf (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rs1data),
    .i_raddr2 (rs2),
    .o_rdata2 (rs2data),
    .i_wb     (i_wb)
  );

  id_branch u_bru (
    .i_rs1data   (rs1data),
    .i_rs2data   (rs2data),
    .i_pc        (ds_pc),
    .i_imm       (imm),
    .i_bren      (bren),
    .i_jump      (jump),
    .i_jalr      (jalr),
    .i_brfunc    (brfunc),
    .o_br_taken  (br_taken),
    .o_br_target (br_target)
  );

  assign o_ds_to_es.rs1data = rs1data;
  assign o_ds_to_es.rs2data = rs2data;
  assign o_ds_to_es.imm     = imm;
  assign o_ds_to_es.pc      = ds_pc;
  assign o_ds_to_es.ctrl    = ctrl;

  assign o_br.stall  = br_stall;
  assign o_br.taken  = br_taken;
  assign o_br.target = br_target;

endmodule

// File: testbench/tb_id_model.svh
// reference model of the decode stage, included inside the testbench module
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

word_t shadow [32];  // register values as write-back left them

function automatic alu_op_t exp_alu(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return alt ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

function automatic imm_t exp_imm(input inst_t in);
  case (in[6:0])
    OPC_OP_IMM, OPC_JALR, OPC_LOAD: return imm_t'($signed(in[31:20]));
    OPC_STORE:  return imm_t'($signed({in[31:25], in[11:7]}));
    OPC_BRANCH: return imm_t'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
    OPC_LUI, OPC_AUIPC: return imm_t'($signed({in[31:12], 12'h000}));
    OPC_JAL: return imm_t'($signed({in[31], in[19:12], in[20], in[30:21], 1'b0}));
    default: return '0;
  endcase
endfunction

function automatic ds_ctrl_t exp_ctrl(input inst_t in);
  ds_ctrl_t   c;
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = in[14:12];
  f7 = in[31:25];
  c = '0;
  c.rd = in[11:7];
  c.mem_op = f3;
  c.gpr_wen = 1'b1;
  case (in[6:0])
    OPC_OP: begin
      c.alu_op = exp_alu(f3, f7[5]);
      c.invalid = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
    end
    OPC_OP_IMM: begin
      c.alu_src2_sel = SRC2_IMM;
      c.alu_op = exp_alu(f3, f3 == 3'd5 && f7[5]);
      if (f3 == 3'd1) c.invalid = in[31:26] != 6'h00;
      if (f3 == 3'd5) c.invalid = in[31:26] != 6'h00 && in[31:26] != 6'h10;
    end
    OPC_LUI:   {c.alu_src2_sel, c.alu_op} = {SRC2_IMM, ALU_PASSB};
    OPC_AUIPC: {c.alu_src1_sel, c.alu_src2_sel} = {1'b1, SRC2_IMM};
    OPC_JAL, OPC_JALR: {c.alu_src1_sel, c.alu_src2_sel} = {1'b1, SRC2_FOUR};
    OPC_BRANCH: c.gpr_wen = 1'b0;
    OPC_LOAD:   {c.alu_src2_sel, c.mem_ren} = {SRC2_IMM, 1'b1};
    OPC_STORE:  {c.alu_src2_sel, c.mem_wen, c.gpr_wen} = {SRC2_IMM, 1'b1, 1'b0};
    default:    c.invalid = 1'b1;
  endcase
  if (c.invalid) {c.gpr_wen, c.mem_ren, c.mem_wen} = 3'b000;
  return c;
endfunction

function automatic logic exp_taken(input inst_t in, input word_t a, input word_t b);
  if (in[6:0] == OPC_JAL || in[6:0] == OPC_JALR) return 1'b1;
  if (in[6:0] != OPC_BRANCH) return 1'b0;
  case (in[14:12])
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic pc_t exp_target(input inst_t in, input pc_t pc, input word_t a);
  pc_t sum;
  sum = a + exp_imm(in);
  if (in[6:0] == OPC_JALR) return {sum[XLEN-1:1], 1'b0};
  return pc + exp_imm(in);
endfunction

`endif

// File: testbench/tb_id_stage.sv
// testbench for the decode stage: random decode, hazard, branch and back-pressure tests
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int PERIOD = 8;
  localparam int N_RAND = 60;
  localparam int N_HAZ  = 30;
  localparam int N_BR   = 40;
  localparam int TEST_CYCLES = 10 + 31 * 2 + N_RAND * 8 + N_HAZ * 12 + N_BR * 14 + 40;

  logic      i_clk;
  logic      i_rst_n;
  logic      i_fs_to_ds_valid;
  fs_to_ds_t i_fs_to_ds;
  logic      o_ds_allowin;
  logic      i_es_allowin;
  logic      o_ds_to_es_valid;
  ds_to_es_t o_ds_to_es;
  br_bus_t   o_br;
  ws_to_rf_t i_wb;
  gpr_addr_t i_es_rd;
  gpr_addr_t i_ms_rd;
  gpr_addr_t i_ws_rd;

  fs_to_ds_t pending[$];  // accepted, not yet passed to execute
  int        errors;
  int        checks;
  int        sent;
  int        out_count;
  int        tests_failed;

  `include "tb_id_model.svh"

  id_stage u_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #(PERIOD / 2) i_clk = ~i_clk;
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (exp === got) else begin
      $display("** Error: %s expected %h got %h at %0t", name, exp, got, $time);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("failure at %0t: %s", $time, what);
      errors++;
    end
  endtask

  // compare whatever the stage offers to execute
  always @(negedge i_clk) begin
    fs_to_ds_t e;
    word_t     a;
    word_t     b;
    if (i_rst_n && o_ds_to_es_valid) begin
      if (pending.size() == 0) begin
        check_true(1'b0, "output valid with no instruction accepted");
      end else begin
        e = pending[0];
        a = shadow[e.inst[19:15]];
        b = shadow[e.inst[24:20]];
        check_val("rs1data", a, o_ds_to_es.rs1data);
        check_val("rs2data", b, o_ds_to_es.rs2data);
        check_val("imm", exp_imm(e.inst), o_ds_to_es.imm);
        check_val("pc", e.pc, o_ds_to_es.pc);
        check_val("ctrl", 64'(exp_ctrl(e.inst)), 64'(o_ds_to_es.ctrl));
        check_val("br.taken", 64'(exp_taken(e.inst, a, b)), 64'(o_br.taken));
        check_val("br.target", exp_target(e.inst, e.pc, a), o_br.target);
        check_val("br.stall", 64'd0, 64'(o_br.stall));
        if (i_es_allowin) begin
          void'(pending.pop_front());
          out_count++;
        end
      end
    end
  end

  task automatic write_reg(input gpr_addr_t addr, input word_t data);
    @(posedge i_clk);
    #1 i_wb = '{wen: 1'b1, waddr: addr, wdata: data};
    @(posedge i_clk);
    if (addr != '0) shadow[addr] = data;
    #1 i_wb.wen = 1'b0;
  endtask

  task automatic offer(input inst_t inst, input pc_t pc);
    @(posedge i_clk);
    #1 i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds = '{inst: inst, pc: pc};
  endtask

  task automatic accept_wait();
    logic acc;
    do begin
      @(negedge i_clk);
      acc = o_ds_allowin;
      @(posedge i_clk);
    end while (!acc);
    pending.push_back(i_fs_to_ds);
    sent++;
    #1 i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds.pc = i_fs_to_ds.pc + 64'd4;  // fetch moves on sequentially
  endtask

  task automatic send(input inst_t inst, input pc_t pc);
    offer(inst, pc);
    accept_wait();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pending.size() != 0 && n < 50) begin
      @(posedge i_clk);
      n++;
    end
    check_true(pending.size() == 0, "instruction never left the stage");
  endtask

  function automatic pc_t rand_pc();
    return {$urandom(), $urandom()} & ~64'h3;
  endfunction

  // non-branch opcodes, some with garbage opcode or funct7
  function automatic inst_t rand_inst();
    inst_t in;
    in = $urandom();
    case ($urandom() % 7)
      0: begin
        in[6:0] = OPC_OP;
        if ($urandom() % 3 != 0) in[31:25] = ($urandom() % 2) ? 7'h20 : 7'h00;
      end
      1: in[6:0] = OPC_OP_IMM;
      2: in[6:0] = OPC_LUI;
      3: in[6:0] = OPC_AUIPC;
      4: in[6:0] = OPC_LOAD;
      5: in[6:0] = OPC_STORE;
      default: begin
        if (in[6:0] inside {OPC_BRANCH, OPC_JAL, OPC_JALR}) in[6:0] = 7'h7f;
      end
    endcase
    return in;
  endfunction

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  task automatic hold_check(input logic exp_stall);
    repeat (3) begin
      @(negedge i_clk);
      check_val("o_ds_to_es_valid", 64'd0, 64'(o_ds_to_es_valid));
      check_val("br.stall", 64'(exp_stall), 64'(o_br.stall));
    end
  endtask

  initial begin
    int        e0;
    int        port;
    inst_t     in;
    pc_t       pc;
    gpr_addr_t rd;
    word_t     a;
    ds_to_es_t snap;
    void'($urandom(23));
    i_rst_n = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds = '0;
    i_es_allowin = 1'b1;
    i_wb = '0;
    {i_es_rd, i_ms_rd, i_ws_rd} = '0;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (4) @(posedge i_clk);
    #1 i_rst_n = 1'b1;
    // registers start unknown, give them all a value
    for (int r = 1; r < 32; r++) write_reg(gpr_addr_t'(r), {$urandom(), $urandom()});

    e0 = errors;
    @(negedge i_clk);
    check_val("o_ds_to_es_valid", 64'd0, 64'(o_ds_to_es_valid));
    check_val("br.stall", 64'd0, 64'(o_br.stall));
    check_val("br.taken", 64'd0, 64'(o_br.taken));
    check_val("o_ds_allowin", 64'd1, 64'(o_ds_allowin));
    end_test("reset", e0);

    e0 = errors;
    for (int k = 0; k < N_RAND; k++) begin
      in = rand_inst();
      if (k % 8 == 0) in[19:15] = '0;  // make sure x0 gets read
      if (k % 8 == 4) in[24:20] = '0;
      write_reg(in[19:15], {$urandom(), $urandom()});
      write_reg(in[24:20], {$urandom(), $urandom()});
      send(in, rand_pc());
      drain();
    end
    end_test("random decode", e0);

    e0 = errors;
    for (int k = 0; k < N_HAZ; k++) begin
      in = {7'h00, gpr_addr_t'($urandom() % 31 + 1), gpr_addr_t'($urandom() % 31 + 1),
            3'd0, gpr_addr_t'($urandom()), OPC_OP};
      send(in, rand_pc());
      if ($urandom() % 2) begin
        rd = ($urandom() % 2) ? in[19:15] : in[24:20];
      end else begin
        do rd = gpr_addr_t'($urandom()); while (rd == in[19:15] || rd == in[24:20]);
      end
      port = $urandom() % 3;
      if (port == 0) i_es_rd = rd;
      else if (port == 1) i_ms_rd = rd;
      else i_ws_rd = rd;
      if (rd == in[19:15] || rd == in[24:20]) begin
        hold_check(1'b1);
        @(posedge i_clk);
        #1 {i_es_rd, i_ms_rd, i_ws_rd} = '0;
      end
      drain();
      @(posedge i_clk);
      #1 {i_es_rd, i_ms_rd, i_ws_rd} = '0;
    end
    end_test("hazard stall", e0);

    e0 = errors;
    for (int k = 0; k < N_BR; k++) begin
      in = $urandom();
      port = $urandom() % 3;
      if (port == 0) begin
        in[6:0] = OPC_BRANCH;
        in[14:12] = (($urandom() % 6) < 2) ? 3'($urandom() % 2) : 3'($urandom() % 4 + 4);
      end else if (port == 1) begin
        in[6:0] = OPC_JAL;
      end else begin
        in[6:0] = OPC_JALR;
        in[14:12] = 3'd0;
      end
      a = {$urandom(), $urandom()};
      write_reg(in[19:15], a);
      write_reg(in[24:20], ($urandom() % 2) ? a : {$urandom(), $urandom()});
      pc = rand_pc();
      send(in, pc);
      a = shadow[in[19:15]];
      if (exp_taken(in, a, shadow[in[24:20]]) && exp_target(in, pc, a) != pc + 64'd4) begin
        hold_check(1'b1);
        @(posedge i_clk);
        #1 i_fs_to_ds.pc = exp_target(in, pc, a);
      end
      drain();
    end
    end_test("branch redirect", e0);

    e0 = errors;
    port = out_count;
    @(posedge i_clk);
    #1 i_es_allowin = 1'b0;
    send(rand_inst(), rand_pc());
    @(negedge i_clk);
    snap = o_ds_to_es;
    offer(rand_inst(), rand_pc());
    repeat (4) begin
      @(negedge i_clk);
      check_val("o_ds_allowin", 64'd0, 64'(o_ds_allowin));
      check_val("o_ds_to_es_valid", 64'd1, 64'(o_ds_to_es_valid));
      check_val("o_ds_to_es.pc", snap.pc, o_ds_to_es.pc);
      check_val("o_ds_to_es.imm", snap.imm, o_ds_to_es.imm);
      check_val("o_ds_to_es.ctrl", 64'(snap.ctrl), 64'(o_ds_to_es.ctrl));
    end
    @(posedge i_clk);
    #1 i_es_allowin = 1'b1;
    accept_wait();
    drain();
    check_val("out_count", 64'(port + 2), 64'(out_count));
    end_test("back-pressure", e0);

    check_true(out_count == sent, "instruction count into and out of the stage differs");
    $display("tests failed %0d of 5, checks %0d, errors %0d", tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 4 * PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: files.f
+incdir+testbench
rtl/id_pkg.sv
rtl/id_ctrl.sv
rtl/id_decoder.sv
rtl/id_regfile.sv
rtl/id_branch.sv
rtl/id_stage.sv
testbench/tb_id_stage.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= files.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard testbench/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^TEST RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
